//--- dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  dcache_pkg::cpu_req_t          req,
    input  dcache_pkg::cpu_req_t          held,
    input  logic                          taken,
    input  logic                          hit,
    input  dcache_pkg::word_t             hit_word,
    input  logic                          fill_done,
    output dcache_pkg::dc_state_t         state,
    output logic                          ready,
    output logic                          data_valid,
    output dcache_pkg::word_t             load_data,
    output logic [dcache_pkg::ADDR_W-1:0] look_addr,
    output logic                          miss_start
);
    import dcache_pkg::*;

    dc_state_t next_state;
    dc_state_t nobusy_ns;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    // where to go whenever ready is high
    assign nobusy_ns = (req.op != OP_NONE) ? S_LOOKUP : S_IDLE;

    always_comb begin
        next_state = state;
        ready      = 1'b0;
        data_valid = 1'b0;
        miss_start = 1'b0;
        case (state)
            S_IDLE: begin
                ready      = 1'b1;
                next_state = nobusy_ns;
            end
            S_LOOKUP: begin
                if (!hit) begin
                    miss_start = 1'b1;
                    next_state = S_MISS;
                end
                else if (held.op == OP_LOAD) begin
                    data_valid = 1'b1;
                    // hold the word until the cpu takes it
                    if (taken) begin
                        ready      = 1'b1;
                        next_state = nobusy_ns;
                    end
                end
                else begin
                    next_state = S_STORE;
                end
            end
            S_STORE: begin
                // lanes land at the end of this cycle
                ready      = 1'b1;
                next_state = nobusy_ns;
            end
            S_MISS: begin
                if (fill_done) begin
                    next_state = S_REFILL;
                end
            end
            S_REFILL: begin
                next_state = S_LOOKUP;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    assign load_data = hit_word;

    // a new request is looked up at the edge that accepts it
    assign look_addr = ready ? req.addr : held.addr;

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    parameter int ADDR_W     = 32;
    parameter int WORD_W     = 32;
    parameter int LINE_WORDS = 8;
    parameter int OFFSET_W   = 5;
    parameter int WAYS       = 2;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;
    typedef logic [WORD_W/8-1:0]          strb_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE_W,
        OP_STORE_H,
        OP_STORE_B
    } cpu_op_t;

    // store data is already placed in its byte lanes
    typedef struct packed {
        cpu_op_t           op;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
    } cpu_req_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_READ_BLOCK,
        MEM_WRITE_BLOCK
    } mem_cmd_t;

    typedef struct packed {
        mem_cmd_t          cmd;
        logic [ADDR_W-1:0] addr;
        line_t             wblock;
    } mem_req_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_STORE,
        S_MISS,
        S_REFILL
    } dc_state_t;

endpackage

//--- dcache_props.sv
`timescale 1ns/10ps

module dcache_props (
    input logic                 clk,
    input logic                 rstn,
    input logic                 taken,
    input logic                 ready,
    input logic                 data_valid,
    input dcache_pkg::word_t    load_data,
    input dcache_pkg::mem_req_t mem_req
);
    import dcache_pkg::*;

    // commands are one-cycle pulses
    cmd_pulse: assert property (@(posedge clk) disable iff (!rstn)
        mem_req.cmd != MEM_NONE |=> mem_req.cmd == MEM_NONE)
        else $error("memory command held for two cycles");

    load_hold: assert property (@(posedge clk) disable iff (!rstn)
        data_valid && !taken |=> data_valid && $stable(load_data))
        else $error("load result dropped or changed before taken");

    ready_excl: assert property (@(posedge clk) disable iff (!rstn)
        ready && data_valid |-> taken)
        else $error("ready and data_valid high without taken");

endmodule

bind dcache_top dcache_props u_props (
    .clk        (clk),
    .rstn       (rstn),
    .taken      (taken),
    .ready      (ready),
    .data_valid (data_valid),
    .load_data  (load_data),
    .mem_req    (mem_req)
);

//--- dcache_top.sv
`timescale 1ns/10ps

module dcache_top #(
    parameter int INDEX_W = 7
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 taken,
    input  dcache_pkg::line_t    mem_rblock,
    input  logic                 mem_done,
    output logic                 ready,
    output logic                 data_valid,
    output dcache_pkg::word_t    load_data,
    output dcache_pkg::mem_req_t mem_req
);
    import dcache_pkg::*;

    cpu_req_t          held;
    strb_t             strb;
    dc_state_t         state;
    logic [ADDR_W-1:0] look_addr;
    logic              hit;
    word_t             hit_word;
    logic              victim_dirty;
    logic [ADDR_W-1:0] victim_addr;
    line_t             victim_line;
    logic              miss_start;
    line_t             fill_line;
    logic              fill_done;

    req_capture u_req_capture (
        .clk   (clk),
        .rstn  (rstn),
        .req   (req),
        .ready (ready),
        .held  (held),
        .strb  (strb)
    );

    dcache_ctrl u_dcache_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .held       (held),
        .taken      (taken),
        .hit        (hit),
        .hit_word   (hit_word),
        .fill_done  (fill_done),
        .state      (state),
        .ready      (ready),
        .data_valid (data_valid),
        .load_data  (load_data),
        .look_addr  (look_addr),
        .miss_start (miss_start)
    );

    way_store #(
        .INDEX_W (INDEX_W)
    ) u_way_store (
        .clk          (clk),
        .rstn         (rstn),
        .look_addr    (look_addr),
        .held         (held),
        .strb         (strb),
        .state        (state),
        .fill_line    (fill_line),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line)
    );

    mem_port u_mem_port (
        .clk          (clk),
        .rstn         (rstn),
        .miss_start   (miss_start),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .held         (held),
        .mem_rblock   (mem_rblock),
        .mem_done     (mem_done),
        .mem_req      (mem_req),
        .fill_line    (fill_line),
        .fill_done    (fill_done)
    );

endmodule

//--- flist.f
dcache_pkg.sv
req_capture.sv
way_store.sv
dcache_ctrl.sv
mem_port.sv
dcache_top.sv
dcache_props.sv
tb_dcache.sv

//--- mem_port.sv
`timescale 1ns/10ps

module mem_port (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          miss_start,
    input  logic                          victim_dirty,
    input  logic [dcache_pkg::ADDR_W-1:0] victim_addr,
    input  dcache_pkg::line_t             victim_line,
    input  dcache_pkg::cpu_req_t          held,
    input  dcache_pkg::line_t             mem_rblock,
    input  logic                          mem_done,
    output dcache_pkg::mem_req_t          mem_req,
    output dcache_pkg::line_t             fill_line,
    output logic                          fill_done
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_WRITE,
        P_READ
    } port_state_t;

    port_state_t       pstate;
    mem_cmd_t          cmd_q;
    logic [ADDR_W-1:0] wb_addr_q;
    line_t             wb_line_q;

    // cmd is a single-cycle pulse
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pstate <= P_IDLE;
            cmd_q  <= MEM_NONE;
        end
        else begin
            cmd_q <= MEM_NONE;
            if (miss_start) begin
                pstate <= victim_dirty ? P_WRITE : P_READ;
                cmd_q  <= victim_dirty ? MEM_WRITE_BLOCK : MEM_READ_BLOCK;
            end
            else if (mem_done && pstate == P_WRITE) begin
                pstate <= P_READ;
                cmd_q  <= MEM_READ_BLOCK;
            end
            else if (mem_done && pstate == P_READ) begin
                pstate <= P_IDLE;
            end
        end
    end

    // victim kept here while the arrays sit idle
    always_ff @(posedge clk) begin
        if (miss_start) begin
            wb_addr_q <= victim_addr;
            wb_line_q <= victim_line;
        end
        if (fill_done) begin
            fill_line <= mem_rblock;
        end
    end

    assign fill_done = (pstate == P_READ) && mem_done;

    always_comb begin
        mem_req.cmd    = cmd_q;
        mem_req.wblock = wb_line_q;
        if (pstate == P_WRITE) begin
            mem_req.addr = wb_addr_q;
        end
        else begin
            mem_req.addr = {held.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

endmodule

//--- req_capture.sv
`timescale 1ns/10ps

module req_capture (
    input  logic                 clk,
    input  logic                 rstn,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 ready,
    output dcache_pkg::cpu_req_t held,
    output dcache_pkg::strb_t    strb
);
    import dcache_pkg::*;

    // request register loaded while the cache is ready
    always_ff @(posedge clk) begin
        if (ready) begin
            held.addr  <= req.addr;
            held.wdata <= req.wdata;
        end
        if (!rstn) begin
            held.op <= OP_NONE;
        end
        else if (ready) begin
            held.op <= req.op;
        end
    end

    // byte lanes from size and low address bits
    always_comb begin
        case (held.op)
            OP_STORE_W: begin
                strb = 4'b1111;
            end
            OP_STORE_H: begin
                strb = held.addr[1] ? 4'b1100 : 4'b0011;
            end
            OP_STORE_B: begin
                strb = 4'b0001 << held.addr[1:0];
            end
            default: begin
                strb = 4'b0000;
            end
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the dcache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int SEQ_LEN = 24;

    typedef struct packed {
        cpu_op_t     op;
        logic [31:0] addr;
        word_t       wdata;
        logic [3:0]  tdly;
        word_t       load_word;
        logic        wb;
        logic        rd;
        logic [31:0] wb_addr;
    } vec_t;

    logic     clk;
    logic     rstn;
    cpu_req_t req;
    logic     taken;
    line_t    mem_rblock;
    logic     mem_done;
    logic     ready;
    logic     data_valid;
    word_t    load_data;
    mem_req_t mem_req;

    logic [15:0] lfsr = 16'd42840;
    line_t       mem [logic [31:0]];
    word_t       shadow [logic [31:0]];
    mem_cmd_t    seen_cmd [$];
    logic [31:0] seen_addr [$];
    vec_t        stim [$];
    int          test_errs;
    int          errors;
    int          ntests;
    int          nfailed;

    // op, addr, wdata, taken delay, load word, write-back, read, write-back addr
    vec_t vecs [11] = '{
        '{OP_LOAD,    32'h0000_1004, 32'h0000_0000, 4'd0, 32'h0000_effb, 1'b0, 1'b1, 32'h0},
        '{OP_LOAD,    32'h0000_1018, 32'h0000_0000, 4'd0, 32'h0000_efe7, 1'b0, 1'b0, 32'h0},
        '{OP_STORE_W, 32'h0000_1008, 32'h1122_3344, 4'd0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{OP_STORE_H, 32'h0000_100a, 32'h5566_0000, 4'd0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{OP_STORE_B, 32'h0000_1009, 32'h0000_7700, 4'd0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
        '{OP_LOAD,    32'h0000_1008, 32'h0000_0000, 4'd4, 32'h5566_7744, 1'b0, 1'b0, 32'h0},
        '{OP_LOAD,    32'h0000_2000, 32'h0000_0000, 4'd0, 32'h0000_dfff, 1'b0, 1'b1, 32'h0},
        '{OP_LOAD,    32'h0000_3010, 32'h0000_0000, 4'd0, 32'h0000_cfef, 1'b1, 1'b1, 32'h1000},
        '{OP_LOAD,    32'h0000_1008, 32'h0000_0000, 4'd0, 32'h5566_7744, 1'b0, 1'b1, 32'h0},
        '{OP_STORE_W, 32'habcd_0044, 32'hdead_beef, 4'd0, 32'h0000_0000, 1'b0, 1'b1, 32'h0},
        '{OP_LOAD,    32'habcd_0044, 32'h0000_0000, 4'd2, 32'hdead_beef, 1'b0, 1'b0, 32'h0}
    };

    dcache_top #(
        .INDEX_W (3)
    ) dut (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .taken      (taken),
        .mem_rblock (mem_rblock),
        .mem_done   (mem_done),
        .ready      (ready),
        .data_valid (data_valid),
        .load_data  (load_data),
        .mem_req    (mem_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t init_word(logic [31:0] a);
        return {a[31:16], ~a[15:0]};
    endfunction

    function automatic word_t golden_word(logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic line_t golden_line(logic [31:0] la);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i*WORD_W +: WORD_W] = golden_word(la + i*4);
        end
        return l;
    endfunction

    function automatic line_t read_line(logic [31:0] la);
        line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i*WORD_W +: WORD_W] = init_word(la + i*4);
        end
        return l;
    endfunction

    // store data arrives already in its byte lanes
    function automatic word_t merge_lanes(word_t old, cpu_op_t op, logic [1:0] ofs, word_t wd);
        word_t w;
        w = old;
        case (op)
            OP_STORE_W: begin
                w = wd;
            end
            OP_STORE_H: begin
                if (ofs[1]) begin
                    w[31:16] = wd[31:16];
                end
                else begin
                    w[15:0] = wd[15:0];
                end
            end
            OP_STORE_B: begin
                w[8*ofs +: 8] = wd[8*ofs +: 8];
            end
            default: begin
                w = old;
            end
        endcase
        return w;
    endfunction

    task automatic check_word(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, want);
            test_errs++;
        end
    endtask

    task automatic check_line(string name, line_t got, line_t want);
        if (got !== want) begin
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, want);
            test_errs++;
        end
    endtask

    task automatic check_cmd(string name, mem_cmd_t got, mem_cmd_t want);
        if (got !== want) begin
            $display("FAIL t=%0t %s got %s exp %s", $time, name, got.name(), want.name());
            test_errs++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic want);
        if (got !== want) begin
            $display("FAIL t=%0t %s got %b exp %b", $time, name, got, want);
            test_errs++;
        end
    endtask

    task automatic check_cmds(vec_t v);
        int k;
        k = 0;
        if (seen_cmd.size() != int'(v.wb) + int'(v.rd)) begin
            $display("memory saw %0d commands where %0d were expected",
                     seen_cmd.size(), int'(v.wb) + int'(v.rd));
            test_errs++;
            return;
        end
        if (v.wb) begin
            check_cmd("mem_req.cmd", seen_cmd[0], MEM_WRITE_BLOCK);
            check_word("mem_req.addr", seen_addr[0], v.wb_addr);
            k = 1;
        end
        if (v.rd) begin
            check_cmd("mem_req.cmd", seen_cmd[k], MEM_READ_BLOCK);
            check_word("mem_req.addr", seen_addr[k], {v.addr[31:5], 5'd0});
        end
    endtask

    // memory model serving one command at a time
    initial begin
        int          delay;
        logic        busy;
        logic        is_read;
        logic [31:0] cur_addr;
        mem_done   = 1'b0;
        mem_rblock = '0;
        delay      = 0;
        busy       = 1'b0;
        is_read    = 1'b0;
        cur_addr   = '0;
        forever begin
            @(negedge clk);
            mem_done = 1'b0;
            if (busy) begin
                if (delay == 0) begin
                    mem_done   = 1'b1;
                    mem_rblock = is_read ? read_line(cur_addr) : '0;
                    busy       = 1'b0;
                end
                else begin
                    delay--;
                end
            end
            if (mem_req.cmd != MEM_NONE) begin
                if (busy) begin
                    $display("memory command issued while another was outstanding");
                    test_errs++;
                end
                seen_cmd.push_back(mem_req.cmd);
                seen_addr.push_back(mem_req.addr);
                if (mem_req.cmd == MEM_WRITE_BLOCK) begin
                    check_line("mem_req.wblock", mem_req.wblock, golden_line(mem_req.addr));
                    mem[mem_req.addr] = mem_req.wblock;
                end
                busy     = 1'b1;
                is_read  = (mem_req.cmd == MEM_READ_BLOCK);
                cur_addr = mem_req.addr;
                delay    = int'(rand_bits(3));
            end
        end
    end

    task automatic run_req(cpu_op_t op, logic [31:0] addr, word_t wdata, int tdly,
                           word_t want);
        word_t first;
        int    n;
        @(negedge clk);
        n = 0;
        while (ready !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("cache never became ready for the request to %h", addr);
            test_errs++;
            return;
        end
        taken = 1'b0;
        req   = '{op, addr, wdata};
        @(negedge clk);
        req = '0;
        n   = 0;
        if (op == OP_LOAD) begin
            while (data_valid !== 1'b1 && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (data_valid !== 1'b1) begin
                $display("no load data returned for %h", addr);
                test_errs++;
                return;
            end
            first = load_data;
            check_word("load_data", first, want);
            for (int i = 0; i < tdly; i++) begin
                // a cold request offered under back-pressure must be ignored
                if (i == 0) begin
                    req = '{OP_LOAD, 32'h8000_0000, 32'h0};
                end
                @(negedge clk);
                check_flag("data_valid", data_valid, 1'b1);
                check_flag("ready", ready, 1'b0);
                check_word("load_data", load_data, first);
            end
            req   = '0;
            taken = 1'b1;
            @(negedge clk);
            taken = 1'b0;
        end
        else begin
            while (ready !== 1'b1 && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (ready !== 1'b1) begin
                $display("store to %h never completed", addr);
                test_errs++;
            end
        end
    endtask

    task automatic report_test(string what);
        ntests++;
        errors += test_errs;
        if (test_errs != 0) begin
            nfailed++;
            $display("test %0d %s: %0d errors", ntests, what, test_errs);
        end
        else begin
            $display("test %0d %s: ok", ntests, what);
        end
    endtask

    task automatic run_test(vec_t v, logic directed);
        word_t       want;
        logic [31:0] wa;
        cpu_op_t     op;
        op        = v.op;
        wa        = {v.addr[31:2], 2'b00};
        test_errs = 0;
        seen_cmd.delete();
        seen_addr.delete();
        want = directed ? v.load_word : golden_word(wa);
        run_req(op, v.addr, v.wdata, int'(v.tdly), want);
        if (op != OP_LOAD) begin
            shadow[wa] = merge_lanes(golden_word(wa), op, v.addr[1:0], v.wdata);
        end
        if (directed) begin
            check_cmds(v);
        end
        report_test($sformatf("%s %h", op.name(), v.addr));
    endtask

    // four tags in set 1 fight over two ways
    task automatic make_sequence(int count);
        vec_t        v;
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            v      = '0;
            r      = rand_bits(2);
            v.addr = {22'd0, r[1:0], 3'b001, 5'd0};
            r      = rand_bits(3);
            v.addr[4:2] = r[2:0];
            r = rand_bits(3);
            case (r)
                4: v.op = OP_STORE_W;
                5: v.op = OP_STORE_H;
                6: v.op = OP_STORE_B;
                default: v.op = OP_LOAD;
            endcase
            r = rand_bits(2);
            if (v.op == OP_STORE_H) begin
                v.addr[1] = r[0];
            end
            if (v.op == OP_STORE_B) begin
                v.addr[1:0] = r[1:0];
            end
            v.wdata = rand_bits(32);
            r       = rand_bits(2);
            v.tdly  = r[3:0];
            stim.push_back(v);
        end
    endtask

    initial begin
        rstn      = 1'b0;
        taken     = 1'b0;
        req       = '0;
        errors    = 0;
        ntests    = 0;
        nfailed   = 0;
        test_errs = 0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_flag("ready", ready, 1'b1);
        check_flag("data_valid", data_valid, 1'b0);
        check_cmd("mem_req.cmd", mem_req.cmd, MEM_NONE);
        report_test("after reset");
        foreach (vecs[i]) begin
            run_test(vecs[i], 1'b1);
        end
        make_sequence(SEQ_LEN);
        repeat (2) begin
            foreach (stim[i]) begin
                run_test(stim[i], 1'b0);
            end
        end
        $display("tests %0d, failed %0d, errors %0d", ntests, nfailed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end
        else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- way_store.sv
`timescale 1ns/10ps

module way_store #(
    parameter int INDEX_W = 7
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [dcache_pkg::ADDR_W-1:0] look_addr,
    input  dcache_pkg::cpu_req_t          held,
    input  dcache_pkg::strb_t             strb,
    input  dcache_pkg::dc_state_t         state,
    input  dcache_pkg::line_t             fill_line,
    output logic                          hit,
    output dcache_pkg::word_t             hit_word,
    output logic                          victim_dirty,
    output logic [dcache_pkg::ADDR_W-1:0] victim_addr,
    output dcache_pkg::line_t             victim_line
);
    import dcache_pkg::*;

    localparam int SETS   = 1 << INDEX_W;
    localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WSEL_W = OFFSET_W - $clog2(WORD_W / 8);

    logic [TAG_W-1:0]           tag_mem [WAYS][SETS];
    line_t                      data_mem [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]  valid;
    logic [WAYS-1:0][SETS-1:0]  dirty;
    // lru bit names the way to evict next
    logic [SETS-1:0]            lru;

    logic [INDEX_W-1:0] idx_q;
    logic [TAG_W-1:0]   req_tag;
    logic [WSEL_W-1:0]  word_sel;
    logic [WAYS-1:0]    way_hit;
    logic               hit_way;
    logic               victim_way;
    line_t              hit_line;
    line_t              merged_line;

    assign req_tag  = held.addr[ADDR_W-1 -: TAG_W];
    assign word_sel = held.addr[OFFSET_W-1 -: WSEL_W];

    // lookup through the registered set index
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid[w][idx_q] && (tag_mem[w][idx_q] == req_tag);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign hit_line   = data_mem[hit_way][idx_q];
    assign hit_word   = hit_line[word_sel*WORD_W +: WORD_W];
    assign victim_way = lru[idx_q];

    assign victim_dirty = valid[victim_way][idx_q] & dirty[victim_way][idx_q];
    assign victim_addr  = {tag_mem[victim_way][idx_q], idx_q, {OFFSET_W{1'b0}}};
    assign victim_line  = data_mem[victim_way][idx_q];

    // merge store lanes into the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (strb[b]) begin
                merged_line[word_sel*WORD_W + b*8 +: 8] = held.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        idx_q <= look_addr[OFFSET_W +: INDEX_W];
        if (state == S_STORE) begin
            data_mem[hit_way][idx_q] <= merged_line;
        end
        if (state == S_REFILL) begin
            data_mem[victim_way][idx_q] <= fill_line;
            tag_mem[victim_way][idx_q]  <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_STORE) begin
            dirty[hit_way][idx_q] <= 1'b1;
        end
        else if (state == S_REFILL) begin
            dirty[victim_way][idx_q] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
            lru   <= '0;
        end
        else begin
            if (state == S_LOOKUP && hit) begin
                lru[idx_q] <= ~hit_way;
            end
            if (state == S_REFILL) begin
                valid[victim_way][idx_q] <= 1'b1;
            end
        end
    end

endmodule
